/* Makefile */
SIM := obj_dir/Vfp_noround_tb
SRCS := $(shell cat project.f)

.PHONY: all run clean

all: run

$(SIM): project.f $(SRCS)
	verilator --binary --timing -j 0 --top-module fp_noround_tb -f project.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/fp_noround_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_noround_tb;

    localparam int NUM_CYCLES    = 4000;
    localparam int RESET_TIMEOUT = 100;     // cycles

    typedef struct packed {
        logic                  valid;
        fpu_op_pkg::fpu_resp_t resp;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    fpu_op_pkg::fpu_req_t  req;
    logic                  valid;
    fpu_op_pkg::fpu_resp_t resp;
    logic                  valid_out;
    logic [31:0]           lfsr_state;
    expect_t               expect_q[$];
    int                    wait_cycles;
    int                    cycle;

    tb_clock_gen #(.RESET_CYCLES(10)) clock_gen0 (.clk_o(clk), .rst_n_o(rst_n));

    fp_noround_unit dut0 (
        .clk_i   ( clk       ),
        .rst_n_i ( rst_n     ),
        .req_i   ( req       ),
        .valid_i ( valid     ),
        .resp_o  ( resp      ),
        .valid_o ( valid_out )
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic make_operand(output logic [31:0] x);
        logic [31:0] pick;
        logic [31:0] sel;
        logic [31:0] sgn;
        logic [31:0] man;
        random_bits(2, pick);
        if (pick[1:0] != 2'd0) begin
            random_bits(32, x);
        end else begin
            random_bits(3, sel);
            random_bits(1, sgn);
            random_bits(23, man);
            case (sel[2:0])
                3'd0: x = {sgn[0], 8'h00, 23'h0};                 // zero
                3'd1: x = {sgn[0], 8'hFF, 23'h0};                 // infinity
                3'd2: x = {sgn[0], 8'hFF, 1'b1, man[21:0]};       // quiet NaN
                3'd3: x = {sgn[0], 8'hFF, 1'b0, man[21:1], 1'b1}; // signaling NaN
                3'd4: x = {sgn[0], 8'h00, man[22:1], 1'b1};       // subnormal
                3'd5: x = 32'h7FC00000;
                3'd6: x = {sgn[0], 8'h01, man[22:0]};             // smallest normals
                default: x = {sgn[0], 8'hFE, man[22:0]};          // largest finite
            endcase
        end
    endtask

    task automatic drive_request();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        make_operand(a);
        make_operand(b);
        random_bits(3, r);
        if (r[2:0] == 3'd0) begin
            b = a;                                  // exact tie
        end else if (r[2:0] == 3'd1) begin
            b = {~a[31], a[30:0]};                  // same magnitude with the other sign
        end
        req.operand_a = a;
        req.operand_b = b;
        random_bits(2, r);
        if (r[1:0] == 2'd3) r[1:0] = 2'd1;
        req.op.unit = fpu_op_pkg::fpu_unit_e'(r[1:0]);
        random_bits(3, r);
        if (r[2:0] > 3'd4) r[2:0] = r[2:0] - 3'd3;
        req.op.cmp_op = fpu_op_pkg::cmp_op_e'(r[2:0]);
        random_bits(2, r);
        req.op.misc_op = fpu_op_pkg::misc_op_e'(r[1:0]);
        random_bits(5, r);
        req.tag = r[4:0];
        random_bits(2, r);
        valid = (r[1:0] != 2'd0);                   // roughly three of four cycles busy
    endtask

    function automatic logic is_nan(input logic [31:0] x);
        return (x[30:23] == 8'hFF) && (x[22:0] != 23'h0);
    endfunction

    function automatic logic is_zero(input logic [31:0] x);
        return x[30:0] == 31'h0;
    endfunction

    // monotonic key where -0 sorts just below +0
    function automatic logic [31:0] order_key(input logic [31:0] x);
        return x[31] ? ~x : {1'b1, x[30:0]};
    endfunction

    function automatic logic [31:0] class_mask(input logic [31:0] x);
        int idx;
        if (x[30:23] == 8'hFF) begin
            if (x[22:0] == 23'h0) idx = x[31] ? 0 : 7;
            else idx = x[22] ? 9 : 8;
        end else if (x[30:23] == 8'h00) begin
            if (x[22:0] == 23'h0) idx = x[31] ? 3 : 4;
            else idx = x[31] ? 2 : 5;
        end else begin
            idx = x[31] ? 1 : 6;
        end
        return 32'h1 << idx;
    endfunction

    function automatic expect_t predict_response(input fpu_op_pkg::fpu_req_t rq, input logic v);
        expect_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic        nan_a;
        logic        nan_b;
        logic        snan;
        logic        zeros;
        logic        a_below;
        e       = '0;
        a       = rq.operand_a;
        b       = rq.operand_b;
        nan_a   = is_nan(a);
        nan_b   = is_nan(b);
        snan    = (nan_a && !a[22]) || (nan_b && !b[22]);
        zeros   = is_zero(a) && is_zero(b);
        a_below = order_key(a) < order_key(b);
        if (!v) return e;
        e.valid    = 1'b1;
        e.resp.tag = rq.tag;
        if (rq.op.unit == fpu_op_pkg::UNIT_CMP) begin
            case (rq.op.cmp_op)
                fpu_op_pkg::CMP_EQ: begin
                    e.resp.result  = {31'b0, !nan_a && !nan_b && (a == b || zeros)};
                    e.resp.invalid = snan;
                end
                fpu_op_pkg::CMP_LT: begin
                    e.resp.result  = {31'b0, !nan_a && !nan_b && !zeros && a_below};
                    e.resp.invalid = nan_a || nan_b;
                end
                fpu_op_pkg::CMP_LE: begin
                    e.resp.result  = {31'b0, !nan_a && !nan_b
                                      && (order_key(a) <= order_key(b) || zeros)};
                    e.resp.invalid = nan_a || nan_b;
                end
                default: begin                      // min and max
                    if (nan_a && nan_b) e.resp.result = 32'h7FC00000;
                    else if (nan_a) e.resp.result = b;
                    else if (nan_b) e.resp.result = a;
                    else if (rq.op.cmp_op == fpu_op_pkg::CMP_MIN) e.resp.result = a_below ? a : b;
                    else e.resp.result = a_below ? b : a;
                    e.resp.invalid = snan;
                end
            endcase
        end else if (rq.op.unit == fpu_op_pkg::UNIT_MISC) begin
            case (rq.op.misc_op)
                fpu_op_pkg::MISC_SGNJ:  e.resp.result = {b[31], a[30:0]};
                fpu_op_pkg::MISC_SGNJN: e.resp.result = {~b[31], a[30:0]};
                fpu_op_pkg::MISC_SGNJX: e.resp.result = {a[31] ^ b[31], a[30:0]};
                default:                e.resp.result = class_mask(a);
            endcase
        end
        return e;
    endfunction

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_response(input expect_t exp);
        assert (valid_out == exp.valid) else begin
            $display("FAIL %0t: valid_o is %b, expected %b", $time, valid_out, exp.valid);
            stop_run();
        end
        assert (resp == exp.resp) else begin
            $display("FAIL %0t: result %h invalid %b tag %h, expected %h %b %h", $time,
                     resp.result, resp.invalid, resp.tag,
                     exp.resp.result, exp.resp.invalid, exp.resp.tag);
            stop_run();
        end
    endtask

    initial begin
        lfsr_state = 32'hef39;
        req        = '0;
        valid      = 1'b0;
        expect_q.push_back('0);                     // idle outputs right after reset
        wait_cycles = 0;
        while (rst_n !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            stop_run();
        end
        for (cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(negedge clk);
            check_response(expect_q.pop_front());
            drive_request();
            expect_q.push_back(predict_response(req, valid));
        end
        @(negedge clk);
        check_response(expect_q.pop_front());
        $display("** PASS **");
        $finish;
    end

endmodule : fp_noround_tb

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;           // 4 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;                      // release away from the sampling edge
    end

endmodule : tb_clock_gen

`default_nettype wire

/* logic/fp_compare.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_compare (
    input  fp_format_pkg::float32_t  operand_a_i,
    input  fp_format_pkg::float32_t  operand_b_i,
    input  fp_format_pkg::fp_class_t class_a_i,
    input  fp_format_pkg::fp_class_t class_b_i,
    input  fpu_op_pkg::cmp_op_e      cmp_op_i,
    output fp_format_pkg::float32_t  result_o,
    output logic                     invalid_o
);

    logic        any_nan;
    logic        any_snan;
    logic        both_zero;
    logic        equal;
    logic        less_total;   // -0 below +0 and NaN ignored
    logic        less;
    logic [30:0] mag_a;
    logic [30:0] mag_b;

    fp_format_pkg::float32_t min_val;
    fp_format_pkg::float32_t max_val;

    assign mag_a = {operand_a_i.exponent, operand_a_i.mantissa};
    assign mag_b = {operand_b_i.exponent, operand_b_i.mantissa};

    assign any_nan   = class_a_i.is_nan | class_b_i.is_nan;
    assign any_snan  = class_a_i.is_snan | class_b_i.is_snan;
    assign both_zero = (class_a_i.is_neg_zero | class_a_i.is_pos_zero)
                     & (class_b_i.is_neg_zero | class_b_i.is_pos_zero);

    always_comb begin : order
        if (operand_a_i.sign != operand_b_i.sign) begin
            less_total = operand_a_i.sign;     // negative a is the smaller one
        end else if (operand_a_i.sign) begin
            less_total = (mag_a > mag_b);      // order flips when both negative
        end else begin
            less_total = (mag_a < mag_b);
        end
    end : order

    // signed zeros count as equal here
    assign equal = !any_nan & ((operand_a_i == operand_b_i) | both_zero);
    assign less  = !any_nan & !both_zero & less_total;

    always_comb begin : minmax_sel
        if (class_a_i.is_nan && class_b_i.is_nan) begin
            min_val = fp_format_pkg::CANONICAL_NAN;
            max_val = fp_format_pkg::CANONICAL_NAN;
        end else if (class_a_i.is_nan) begin
            min_val = operand_b_i;
            max_val = operand_b_i;
        end else if (class_b_i.is_nan) begin
            min_val = operand_a_i;
            max_val = operand_a_i;
        end else begin
            min_val = less_total ? operand_a_i : operand_b_i;
            max_val = less_total ? operand_b_i : operand_a_i;
        end
    end : minmax_sel

    always_comb begin : op_sel
        result_o  = '0;
        invalid_o = 1'b0;
        case (cmp_op_i)
            fpu_op_pkg::CMP_EQ: begin
                result_o  = {31'b0, equal};
                invalid_o = any_snan;          // quiet compare
            end
            fpu_op_pkg::CMP_LT: begin
                result_o  = {31'b0, less};
                invalid_o = any_nan;           // signaling compare
            end
            fpu_op_pkg::CMP_LE: begin
                result_o  = {31'b0, less | equal};
                invalid_o = any_nan;
            end
            fpu_op_pkg::CMP_MIN: begin
                result_o  = min_val;
                invalid_o = any_snan;
            end
            fpu_op_pkg::CMP_MAX: begin
                result_o  = max_val;
                invalid_o = any_snan;
            end
            default: ;                         // undefined opcode gives zero
        endcase
    end : op_sel

    // an sNaN operand must never leak out of min or max
    always_comb begin : minmax_check
        if (cmp_op_i == fpu_op_pkg::CMP_MIN || cmp_op_i == fpu_op_pkg::CMP_MAX) begin
            a_minmax_no_snan: assert final (!(result_o.exponent == fp_format_pkg::EXP_ALL_ONES
                && result_o.mantissa != '0 && !result_o.mantissa[22]));
        end
    end : minmax_check

endmodule : fp_compare

`default_nettype wire

/* logic/fp_format_pkg.sv */
`default_nettype none

package fp_format_pkg;

    typedef logic [7:0]  exponent_t;   // biased exponent field
    typedef logic [22:0] mantissa_t;   // fraction without hidden bit

    // single precision word with sign in bit 31
    typedef struct packed {
        logic      sign;
        exponent_t exponent;
        mantissa_t mantissa;
    } float32_t;

    // class flags of one operand
    // the eight ordered flags are one-hot for non-NaN values
    typedef struct packed {
        logic is_neg_inf;
        logic is_neg_normal;
        logic is_neg_subnormal;
        logic is_neg_zero;
        logic is_pos_zero;
        logic is_pos_subnormal;
        logic is_pos_normal;
        logic is_pos_inf;
        logic is_snan;
        logic is_qnan;
        logic is_nan;
    } fp_class_t;

    localparam exponent_t EXP_ALL_ONES = 8'hFF;             // inf and NaN exponent

    localparam float32_t CANONICAL_NAN = 32'h7FC00000;      // positive quiet NaN

endpackage : fp_format_pkg

`default_nettype wire

/* logic/fp_noround_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_noround_unit (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  fpu_op_pkg::fpu_req_t  req_i,
    input  logic                  valid_i,
    output fpu_op_pkg::fpu_resp_t resp_o,
    output logic                  valid_o
);

    fp_format_pkg::fp_class_t class_a;
    fp_format_pkg::fp_class_t class_b;
    fp_format_pkg::float32_t  cmp_result;
    fp_format_pkg::float32_t  misc_result;
    logic                     cmp_invalid;

    fp_operand_classifier classify_a (
        .operand_i ( req_i.operand_a ),
        .class_o   ( class_a         )
    );

    fp_operand_classifier classify_b (
        .operand_i ( req_i.operand_b ),
        .class_o   ( class_b         )
    );

    fp_compare compare0 (
        .operand_a_i ( req_i.operand_a  ),
        .operand_b_i ( req_i.operand_b  ),
        .class_a_i   ( class_a          ),
        .class_b_i   ( class_b          ),
        .cmp_op_i    ( req_i.op.cmp_op  ),
        .result_o    ( cmp_result       ),
        .invalid_o   ( cmp_invalid      )
    );

    fp_sign_class sign_class0 (
        .operand_a_i ( req_i.operand_a  ),
        .operand_b_i ( req_i.operand_b  ),
        .class_a_i   ( class_a          ),
        .misc_op_i   ( req_i.op.misc_op ),
        .result_o    ( misc_result      )
    );

    fpu_result_ctrl result_ctrl0 (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .req_i         ( req_i       ),
        .valid_i       ( valid_i     ),
        .cmp_result_i  ( cmp_result  ),
        .cmp_invalid_i ( cmp_invalid ),
        .misc_result_i ( misc_result ),
        .resp_o        ( resp_o      ),
        .valid_o       ( valid_o     )
    );

endmodule : fp_noround_unit

`default_nettype wire

/* logic/fp_operand_classifier.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_operand_classifier (
    input  fp_format_pkg::float32_t  operand_i,
    output fp_format_pkg::fp_class_t class_o
);

    logic exp_ones;
    logic exp_zero;
    logic man_zero;
    logic is_inf;
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic neg;

    assign exp_ones = (operand_i.exponent == fp_format_pkg::EXP_ALL_ONES);
    assign exp_zero = (operand_i.exponent == '0);
    assign man_zero = (operand_i.mantissa == '0);
    assign neg      = operand_i.sign;

    assign is_inf       = exp_ones & man_zero;
    assign is_normal    = !exp_ones & !exp_zero;
    assign is_subnormal = exp_zero & !man_zero;
    assign is_zero      = exp_zero & man_zero;

    always_comb begin : class_decode
        class_o.is_neg_inf       = is_inf & neg;
        class_o.is_neg_normal    = is_normal & neg;
        class_o.is_neg_subnormal = is_subnormal & neg;
        class_o.is_neg_zero      = is_zero & neg;
        class_o.is_pos_zero      = is_zero & !neg;
        class_o.is_pos_subnormal = is_subnormal & !neg;
        class_o.is_pos_normal    = is_normal & !neg;
        class_o.is_pos_inf       = is_inf & !neg;

        // quiet bit is the top fraction bit
        class_o.is_nan  = exp_ones & !man_zero;
        class_o.is_snan = exp_ones & !man_zero & !operand_i.mantissa[22];
        class_o.is_qnan = exp_ones & operand_i.mantissa[22];
    end : class_decode

endmodule : fp_operand_classifier

`default_nettype wire

/* logic/fp_sign_class.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_sign_class (
    input  fp_format_pkg::float32_t  operand_a_i,
    input  fp_format_pkg::float32_t  operand_b_i,
    input  fp_format_pkg::fp_class_t class_a_i,
    input  fpu_op_pkg::misc_op_e     misc_op_i,
    output fp_format_pkg::float32_t  result_o
);

    logic [9:0] class_mask;
    logic       new_sign;

    // bit 0 is negative infinity, bit 9 quiet NaN
    assign class_mask = {
        class_a_i.is_qnan,
        class_a_i.is_snan,
        class_a_i.is_pos_inf,
        class_a_i.is_pos_normal,
        class_a_i.is_pos_subnormal,
        class_a_i.is_pos_zero,
        class_a_i.is_neg_zero,
        class_a_i.is_neg_subnormal,
        class_a_i.is_neg_normal,
        class_a_i.is_neg_inf
    };

    always_comb begin : sign_sel
        case (misc_op_i)
            fpu_op_pkg::MISC_SGNJN: new_sign = !operand_b_i.sign;
            fpu_op_pkg::MISC_SGNJX: new_sign = operand_a_i.sign ^ operand_b_i.sign;
            default:                new_sign = operand_b_i.sign;
        endcase
    end : sign_sel

    always_comb begin : result_sel
        if (misc_op_i == fpu_op_pkg::MISC_CLASS) begin
            result_o = {22'b0, class_mask};          // zero extended mask
        end else begin
            result_o          = operand_a_i;         // keep a's magnitude
            result_o.sign     = new_sign;
        end
    end : result_sel

endmodule : fp_sign_class

`default_nettype wire

/* logic/fpu_op_pkg.sv */
`default_nettype none

package fpu_op_pkg;

    typedef logic [4:0] tag_t;   // destination tag riding along with the request

    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,
        UNIT_CMP  = 2'd1,
        UNIT_MISC = 2'd2
    } fpu_unit_e;

    typedef enum logic [2:0] {
        CMP_EQ  = 3'd0,
        CMP_LT  = 3'd1,
        CMP_LE  = 3'd2,
        CMP_MIN = 3'd3,
        CMP_MAX = 3'd4
    } cmp_op_e;

    typedef enum logic [1:0] {
        MISC_SGNJ  = 2'd0,
        MISC_SGNJN = 2'd1,
        MISC_SGNJX = 2'd2,
        MISC_CLASS = 2'd3
    } misc_op_e;

    typedef struct packed {
        fpu_unit_e unit;
        cmp_op_e   cmp_op;
        misc_op_e  misc_op;
    } fpu_op_t;

    typedef struct packed {
        fp_format_pkg::float32_t operand_a;
        fp_format_pkg::float32_t operand_b;
        fpu_op_t                 op;
        tag_t                    tag;
    } fpu_req_t;

    typedef struct packed {
        fp_format_pkg::float32_t result;
        logic                    invalid;
        tag_t                    tag;
    } fpu_resp_t;

endpackage : fpu_op_pkg

`default_nettype wire

/* logic/fpu_result_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_result_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  fpu_op_pkg::fpu_req_t    req_i,
    input  logic                    valid_i,
    input  fp_format_pkg::float32_t cmp_result_i,
    input  logic                    cmp_invalid_i,
    input  fp_format_pkg::float32_t misc_result_i,
    output fpu_op_pkg::fpu_resp_t   resp_o,
    output logic                    valid_o
);

    fp_format_pkg::float32_t result_sel;
    logic                    invalid_sel;

    always_comb begin : unit_decode
        result_sel  = '0;
        invalid_sel = 1'b0;
        case (req_i.op.unit)
            fpu_op_pkg::UNIT_CMP: begin
                result_sel  = cmp_result_i;
                invalid_sel = cmp_invalid_i;
            end
            fpu_op_pkg::UNIT_MISC: begin
                result_sel  = misc_result_i;   // misc group never raises invalid
            end
            default: ;                         // UNIT_NONE answers with zero
        endcase
    end : unit_decode

    // output stage cleared on every edge without a request
    always_ff @(posedge clk_i) begin : resp_stage
        if (!rst_n_i || !valid_i) begin
            resp_o <= '0;
        end else begin
            resp_o.result  <= result_sel;
            resp_o.invalid <= invalid_sel;
            resp_o.tag     <= req_i.tag;
        end
    end : resp_stage

    always_ff @(posedge clk_i) begin : valid_stage
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end : valid_stage

    // requester must only send encodings the datapaths know
    a_defined_op: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> (req_i.op.unit inside {fpu_op_pkg::UNIT_NONE, fpu_op_pkg::UNIT_CMP,
                                           fpu_op_pkg::UNIT_MISC})
                 && (req_i.op.unit != fpu_op_pkg::UNIT_CMP
                     || req_i.op.cmp_op inside {fpu_op_pkg::CMP_EQ, fpu_op_pkg::CMP_LT,
                                                fpu_op_pkg::CMP_LE, fpu_op_pkg::CMP_MIN,
                                                fpu_op_pkg::CMP_MAX}));

endmodule : fpu_result_ctrl

`default_nettype wire

/* project.f */
logic/fp_format_pkg.sv
logic/fpu_op_pkg.sv
logic/fp_operand_classifier.sv
logic/fp_compare.sv
logic/fp_sign_class.sv
logic/fpu_result_ctrl.sv
logic/fp_noround_unit.sv
bench/tb_clock_gen.sv
bench/fp_noround_tb.sv
